/* Bender.yml */
package:
  name: vecRead

sources:
  - files:
      - design/busPkg.sv
      - design/lanePkg.sv
      - design/addrSweep.sv
      - design/pingPongBuffer.sv
      - design/readLane.sv
      - design/busArbiter.sv
      - design/laneLauncher.sv
      - design/vecReadTop.sv
  - target: simulation
    files:
      - dv/busResponder.sv
      - dv/vecReadTb.sv

/* design/addrSweep.sv */
`timescale 1ns/1ns

module addrSweep import lanePkg::*; (
   input  logic                  clk,
   input  logic                  rst,
   input  logic                  run,
   input  laneCfg                cfg,
   input  logic                  bankSel,
   output logic                  rdEn,
   output logic [BUF_ADDR_W-1:0] rdAddr,
   output logic                  sweepDone
);

   logic [BANK_ADDR_W-1:0] idx;
   logic [5:0]             remaining;
   logic [PERIOD_W-1:0]    timer;
   logic                   bank;

   function automatic logic [BANK_ADDR_W-1:0] mapIdx(input logic [BANK_ADDR_W-1:0] i,
                                                    input logic rev);
      logic [BANK_ADDR_W-1:0] r;
      for (int b = 0; b < BANK_ADDR_W; b++) begin
         r[b] = i[BANK_ADDR_W-1-b];
      end
      return rev ? r : i;
   endfunction

   always_ff @(posedge clk or posedge rst) begin
      if (rst) begin
         rdEn      <= 1'b0;
         rdAddr    <= '0;
         idx       <= '0;
         remaining <= '0;
         timer     <= '0;
         bank      <= 1'b0;
         sweepDone <= 1'b1;
      end else if (run) begin
         // bank is latched here, the lane flips its own copy at the same edge
         bank <= bankSel;
         if (cfg.count == '0) begin
            rdEn      <= 1'b0;
            remaining <= '0;
            sweepDone <= 1'b1;
         end else begin
            rdEn      <= 1'b1;
            rdAddr    <= {bankSel, mapIdx(cfg.start, cfg.reverse)};
            idx       <= cfg.start + cfg.incr;
            remaining <= cfg.count - 1'b1;
            timer     <= cfg.period - 1'b1;
            sweepDone <= 1'b0;
         end
      end else begin
         rdEn <= 1'b0;
         if (remaining != '0) begin
            if (timer == '0) begin
               rdEn      <= 1'b1;
               rdAddr    <= {bank, mapIdx(idx, cfg.reverse)};
               idx       <= idx + cfg.incr;
               remaining <= remaining - 1'b1;
               timer     <= cfg.period - 1'b1;
            end else begin
               timer <= timer - 1'b1;
            end
         end else begin
            sweepDone <= 1'b1;
         end
      end
   end

endmodule

/* design/busArbiter.sv */
`timescale 1ns/1ns

module busArbiter import busPkg::*; #(
   parameter int NUM_LANES = 4
) (
   input  logic                 clk,
   input  logic                 rst,
   input  logic [NUM_LANES-1:0] laneReq,
   input  busReq                laneBurst [NUM_LANES],
   output logic [NUM_LANES-1:0] laneAck,
   output logic [NUM_LANES-1:0] beatSel,
   output logic                 extReq,
   output busReq                extBurst,
   input  logic                 extAck,
   input  busBeat               extBeat
);

   localparam int GW = (NUM_LANES > 1) ? $clog2(NUM_LANES) : 1;

   typedef enum logic [1:0] {stIdle, stForward, stRelease} arbState;

   arbState       state;
   logic [GW-1:0] grant;
   logic [GW-1:0] nextGrant;

   // nearest requester after the last one served wins
   always_comb begin
      int cand;
      nextGrant = grant;
      for (int i = NUM_LANES; i >= 1; i--) begin
         cand = (grant + i) % NUM_LANES;
         if (laneReq[cand]) begin
            nextGrant = GW'(cand);
         end
      end
   end

   always_ff @(posedge clk or posedge rst) begin
      if (rst) begin
         state <= stIdle;
         grant <= GW'(NUM_LANES - 1);
      end else begin
         case (state)
            stIdle:
               if (|laneReq) begin
                  grant <= nextGrant;
                  state <= stForward;
               end
            stForward:
               if (extAck) begin
                  state <= stRelease;
               end
            // wait for both sides to close their handshakes
            stRelease:
               if (!extAck && !laneReq[grant]) begin
                  state <= stIdle;
               end
            default:
               state <= stIdle;
         endcase
      end
   end

   always_comb begin
      laneAck = '0;
      beatSel = '0;
      if (state == stRelease) begin
         laneAck[grant] = 1'b1;
      end
      if (state == stForward) begin
         beatSel[grant] = extBeat.valid;
      end
   end

   assign extReq   = (state == stForward);
   assign extBurst = laneBurst[grant];

   ackNeedsGrant: assert property (@(posedge clk) disable iff (rst)
      extAck |-> (state != stIdle));
   // beats only ever land in a lane that still holds its request
   oneBeatTarget: assert property (@(posedge clk) disable iff (rst)
      $onehot0(beatSel) && ((beatSel & ~laneReq) == '0));

endmodule

/* design/busPkg.sv */
package busPkg;

   // external word address and data widths
   localparam int EXT_ADDR_W = 32;
   localparam int DATA_W     = 32;

   // burst length field, legal values 1 to 32
   localparam int LEN_W = 6;

   // one burst read request
   typedef struct packed {
      logic [EXT_ADDR_W-1:0] addr;
      logic [LEN_W-1:0]      len;
   } busReq;

   // one returned word
   typedef struct packed {
      logic              valid;
      logic [DATA_W-1:0] data;
   } busBeat;

endpackage

/* design/laneLauncher.sv */
`timescale 1ns/1ns

module laneLauncher #(
   parameter int NUM_LANES = 4
) (
   input  logic                 clk,
   input  logic                 rst,
   input  logic                 start,
   input  lanePkg::laneCfg      cfg [NUM_LANES],
   output logic                 busy,
   output logic                 done,
   output logic                 run,
   output lanePkg::laneCfg      laneCfg [NUM_LANES],
   input  logic [NUM_LANES-1:0] laneDone
);

   logic lenOk;

   always_comb begin
      lenOk = 1'b1;
      for (int i = 0; i < NUM_LANES; i++) begin
         if (cfg[i].len == '0) begin
            lenOk = 1'b0;
         end
      end
   end

   // captured config stays put until the next accepted start
   always_ff @(posedge clk) begin
      if (start && !busy) begin
         laneCfg <= cfg;
      end
   end

   always_ff @(posedge clk or posedge rst) begin
      if (rst) begin
         busy <= 1'b0;
         done <= 1'b0;
         run  <= 1'b0;
      end else begin
         run  <= 1'b0;
         done <= 1'b0;
         if (!busy) begin
            if (start) begin
               busy <= 1'b1;
               run  <= 1'b1;
            end
         end else if (!run && (&laneDone)) begin
            // lanes clear their done flags on the run edge
            busy <= 1'b0;
            done <= 1'b1;
         end
      end
   end

   noEmptyFill: assert property (@(posedge clk) disable iff (rst) (start && !busy) |-> lenOk);

endmodule

/* design/lanePkg.sv */
package lanePkg;

   // 32 words per bank, two banks per lane
   localparam int BANK_ADDR_W = 5;
   localparam int BUF_ADDR_W  = 6;

   localparam int PERIOD_W = 4;

   // everything one lane needs for a single run
   typedef struct packed {
      logic [31:0]            extAddr;
      logic [5:0]             len;
      logic [BANK_ADDR_W-1:0] start;
      // stride wraps modulo 32
      logic [BANK_ADDR_W-1:0] incr;
      // output words, 0 to 32
      logic [5:0]             count;
      // cycles between outputs, at least 1
      logic [PERIOD_W-1:0]    period;
      logic                   reverse;
   } laneCfg;

   // one output word
   typedef struct packed {
      logic        valid;
      logic [31:0] data;
   } laneBeat;

endpackage

/* design/pingPongBuffer.sv */
`timescale 1ns/1ns

module pingPongBuffer import busPkg::*, lanePkg::*; (
   input  logic                  clk,
   input  logic                  wrEn,
   input  logic [BUF_ADDR_W-1:0] wrAddr,
   input  logic [DATA_W-1:0]     wrData,
   input  logic                  rdEn,
   input  logic [BUF_ADDR_W-1:0] rdAddr,
   output logic [DATA_W-1:0]     rdData
);

   // top address bit picks the bank
   logic [DATA_W-1:0] mem [2**BUF_ADDR_W];

   always_ff @(posedge clk) begin
      if (wrEn) begin
         mem[wrAddr] <= wrData;
      end
   end

   always_ff @(posedge clk) begin
      if (rdEn) begin
         rdData <= mem[rdAddr];
      end
   end

   // fill and sweep always sit in opposite banks
   noCollision: assert property (@(posedge clk) !(wrEn && rdEn && (wrAddr == rdAddr)));

endmodule

/* design/readLane.sv */
`timescale 1ns/1ns

module readLane import busPkg::*, lanePkg::*; (
   input  logic    clk,
   input  logic    rst,
   input  logic    run,
   input  laneCfg  cfg,
   output logic    laneReq,
   output busReq   laneBurst,
   input  logic    laneAck,
   input  busBeat  beatIn,
   input  logic    beatSel,
   output laneBeat laneOut,
   output logic    laneDone
);

   logic                  fillBank;
   logic [5:0]            wrCnt;
   logic                  fillDone;
   logic                  wrEn;
   logic                  rdEn;
   logic [BUF_ADDR_W-1:0] rdAddr;
   logic [DATA_W-1:0]     rdData;
   logic                  sweepDone;
   logic                  outValid;

   // config is held by the launcher for the whole run
   assign laneBurst = '{addr: cfg.extAddr, len: cfg.len};
   assign wrEn      = beatIn.valid && beatSel;

   always_ff @(posedge clk or posedge rst) begin
      if (rst) begin
         fillBank <= 1'b0;
         laneReq  <= 1'b0;
         wrCnt    <= '0;
         fillDone <= 1'b1;
         outValid <= 1'b0;
      end else begin
         outValid <= rdEn;
         if (run) begin
            fillBank <= ~fillBank;
            laneReq  <= 1'b1;
            wrCnt    <= '0;
            fillDone <= 1'b0;
         end else begin
            if (wrEn) begin
               wrCnt <= wrCnt + 1'b1;
            end
            // four-phase: drop req on ack, finish once ack is gone
            if (laneReq && laneAck) begin
               laneReq <= 1'b0;
            end else if (!laneReq && !laneAck && !fillDone) begin
               fillDone <= 1'b1;
            end
         end
      end
   end

   addrSweep sweep (
      .clk       (clk),
      .rst       (rst),
      .run       (run),
      .cfg       (cfg),
      .bankSel   (fillBank),
      .rdEn      (rdEn),
      .rdAddr    (rdAddr),
      .sweepDone (sweepDone)
   );

   pingPongBuffer buffer (
      .clk    (clk),
      .wrEn   (wrEn),
      .wrAddr ({fillBank, wrCnt[BANK_ADDR_W-1:0]}),
      .wrData (beatIn.data),
      .rdEn   (rdEn),
      .rdAddr (rdAddr),
      .rdData (rdData)
   );

   assign laneOut  = '{valid: outValid, data: rdData};
   assign laneDone = fillDone && sweepDone;

   // responder and arbiter must stop at len beats
   noExtraBeat: assert property (@(posedge clk) disable iff (rst)
      wrEn |-> (wrCnt < cfg.len));

endmodule

/* design/vecReadTop.sv */
`timescale 1ns/1ns

module vecReadTop import busPkg::*, lanePkg::*; #(
   parameter int NUM_LANES = 4
) (
   input  logic    clk,
   input  logic    rst,
   input  logic    start,
   input  laneCfg  cfg [NUM_LANES],
   output logic    busy,
   output logic    done,
   output logic    extReq,
   output busReq   extBurst,
   input  logic    extAck,
   input  busBeat  extBeat,
   output laneBeat laneOut [NUM_LANES]
);

   logic                 run;
   laneCfg               cfgRun [NUM_LANES];
   logic [NUM_LANES-1:0] laneReq;
   busReq                laneBurst [NUM_LANES];
   logic [NUM_LANES-1:0] laneAck;
   logic [NUM_LANES-1:0] beatSel;
   logic [NUM_LANES-1:0] laneDone;

   laneLauncher #(.NUM_LANES(NUM_LANES)) launcher (
      .clk      (clk),
      .rst      (rst),
      .start    (start),
      .cfg      (cfg),
      .busy     (busy),
      .done     (done),
      .run      (run),
      .laneCfg  (cfgRun),
      .laneDone (laneDone)
   );

   for (genvar i = 0; i < NUM_LANES; i++) begin : gLane
      // beats go to every lane, beatSel picks the owner
      readLane lane (
         .clk       (clk),
         .rst       (rst),
         .run       (run),
         .cfg       (cfgRun[i]),
         .laneReq   (laneReq[i]),
         .laneBurst (laneBurst[i]),
         .laneAck   (laneAck[i]),
         .beatIn    (extBeat),
         .beatSel   (beatSel[i]),
         .laneOut   (laneOut[i]),
         .laneDone  (laneDone[i])
      );
   end

   busArbiter #(.NUM_LANES(NUM_LANES)) arbiter (
      .clk       (clk),
      .rst       (rst),
      .laneReq   (laneReq),
      .laneBurst (laneBurst),
      .laneAck   (laneAck),
      .beatSel   (beatSel),
      .extReq    (extReq),
      .extBurst  (extBurst),
      .extAck    (extAck),
      .extBeat   (extBeat)
   );

endmodule

/* dv/busResponder.sv */
`timescale 1ns/1ns

module busResponder import busPkg::*; (
   input  logic   clk,
   input  logic   rst,
   input  logic   extReq,
   input  busReq  extBurst,
   output logic   extAck,
   output busBeat extBeat
);

   // word table and idle gaps, both loaded by the testbench
   logic [DATA_W-1:0] mem [1024];
   logic [1:0]        gaps [1024];

   typedef enum logic [1:0] {rsIdle, rsBeats, rsAck} respState;

   respState         state;
   logic [9:0]       addr;
   logic [LEN_W-1:0] left;
   logic [1:0]       idle;
   logic [9:0]       gapIdx;

   always @(posedge clk or posedge rst) begin
      if (rst) begin
         state   <= rsIdle;
         extAck  <= 1'b0;
         extBeat <= '0;
         addr    <= '0;
         left    <= '0;
         idle    <= '0;
         gapIdx  <= '0;
      end else begin
         extBeat.valid <= 1'b0;
         case (state)
            rsIdle:
               if (extReq) begin
                  addr   <= extBurst.addr[9:0];
                  left   <= extBurst.len;
                  idle   <= gaps[gapIdx];
                  gapIdx <= gapIdx + 1'b1;
                  state  <= rsBeats;
               end
            rsBeats:
               if (idle != '0) begin
                  idle <= idle - 1'b1;
               end else if (left != '0) begin
                  extBeat <= '{valid: 1'b1, data: mem[addr]};
                  addr    <= addr + 1'b1;
                  left    <= left - 1'b1;
                  idle    <= gaps[gapIdx];
                  gapIdx  <= gapIdx + 1'b1;
               end else begin
                  extAck <= 1'b1;
                  state  <= rsAck;
               end
            // hold ack until the request is withdrawn
            rsAck:
               if (!extReq) begin
                  extAck <= 1'b0;
                  state  <= rsIdle;
               end
            default:
               state <= rsIdle;
         endcase
      end
   end

endmodule

/* dv/vecReadTb.sv */
`timescale 1ns/1ns

module vecReadTb
   import busPkg::*, lanePkg::*;
();

   localparam int NL      = 4;
   localparam int TIMEOUT = 2000;

   logic    clk;
   logic    rst;
   logic    start;
   laneCfg  cfg [NL];
   logic    busy;
   logic    done;
   logic    extReq;
   busReq   extBurst;
   logic    extAck;
   busBeat  extBeat;
   laneBeat laneOut [NL];

   logic [31:0] lfsrState;
   logic [31:0] memTable [1024];
   logic [31:0] bankImg [NL][2][32];
   bit          modelBank [NL];
   bit          primed [NL];
   laneCfg      nextCfg [NL];

   // filled by the monitor at the falling edge
   logic [31:0] gotWords [NL][64];
   int          gotCnt [NL];
   busReq       seenBursts [16];
   int          seenCnt;
   int          doneCnt;
   logic        reqSeen;
   logic        prevBusy;

   int errors;
   int testsRun;
   int testsFailed;
   bit timedOut;

   vecReadTop #(.NUM_LANES(NL)) dut0 (
      .clk      (clk),
      .rst      (rst),
      .start    (start),
      .cfg      (cfg),
      .busy     (busy),
      .done     (done),
      .extReq   (extReq),
      .extBurst (extBurst),
      .extAck   (extAck),
      .extBeat  (extBeat),
      .laneOut  (laneOut)
   );

   busResponder responder (
      .clk      (clk),
      .rst      (rst),
      .extReq   (extReq),
      .extBurst (extBurst),
      .extAck   (extAck),
      .extBeat  (extBeat)
   );

   initial begin
      clk = 1'b0;
      forever #4 clk = ~clk;
   end

   // galois lfsr, one step per bit taken
   function automatic logic [31:0] randBits(input int n);
      logic [31:0] r;
      r = '0;
      for (int b = 0; b < n; b++) begin
         lfsrState = lfsrState[0] ? ((lfsrState >> 1) ^ 32'h8020_0003) : (lfsrState >> 1);
         r = {r[30:0], lfsrState[0]};
      end
      return r;
   endfunction

   task automatic logMismatch(input string name, input logic [31:0] got,
                              input logic [31:0] exp);
      errors++;
      $display("mismatch %s: got %h, expected %h", name, got, exp);
   endtask

   task automatic noteFault(input string what);
      errors++;
      $display("%s", what);
   endtask

   task automatic finishTest(input string name, input int errStart);
      testsRun++;
      if (errors == errStart && !timedOut) begin
         $display("test %-20s passed", name);
      end else begin
         testsFailed++;
         $display("test %-20s FAILED, %0d errors", name, errors - errStart);
      end
   endtask

   always @(negedge clk) begin
      if (!rst) begin
         for (int i = 0; i < NL; i++) begin
            if (laneOut[i].valid) begin
               if (gotCnt[i] < 64) begin
                  gotWords[i][gotCnt[i]] = laneOut[i].data;
               end
               gotCnt[i]++;
            end
         end
         if (extReq && !reqSeen) begin
            if (seenCnt < 16) begin
               seenBursts[seenCnt] = extBurst;
            end
            seenCnt++;
         end
         reqSeen = extReq;
         if (done) begin
            doneCnt++;
            if (!prevBusy) begin
               noteFault("done pulse came while busy was already low");
            end
         end
         prevBusy = busy;
      end
   end

   // mode 0 plain replay, 1 stride and reversal, 2 partial bursts
   task automatic makeCfgs(input int mode);
      for (int i = 0; i < NL; i++) begin
         nextCfg[i].extAddr = randBits(32);
         nextCfg[i].len     = (mode == 2) ? 6'(1 + randBits(5)) : 6'd32;
         nextCfg[i].start   = (mode == 0) ? 5'd0 : 5'(randBits(5));
         nextCfg[i].incr    = (mode == 0) ? 5'd1 : 5'(randBits(5));
         nextCfg[i].count   = (mode == 0) ? 6'd32 : 6'(randBits(6) % 33);
         nextCfg[i].period  = 4'(1 + randBits(2));
         nextCfg[i].reverse = (mode == 0) ? 1'b0 : 1'(randBits(1));
      end
   endtask

   task automatic runOnce(input bit poke);
      logic [31:0]            expWords [NL][32];
      int                     expCnt [NL];
      bit                     used [NL];
      bit                     ok;
      bit                     hit;
      logic [BANK_ADDR_W-1:0] idx;
      logic [9:0]             a;
      // sweep replays the bank written by the previous fill
      for (int i = 0; i < NL; i++) begin
         expCnt[i] = int'(nextCfg[i].count);
         used[i]   = 1'b0;
         for (int k = 0; k < expCnt[i]; k++) begin
            idx = 5'((int'(nextCfg[i].start) + k * int'(nextCfg[i].incr)) % 32);
            if (nextCfg[i].reverse) begin
               idx = {idx[0], idx[1], idx[2], idx[3], idx[4]};
            end
            expWords[i][k] = bankImg[i][modelBank[i]][idx];
         end
      end
      @(posedge clk);
      for (int i = 0; i < NL; i++) begin
         gotCnt[i] = 0;
      end
      seenCnt = 0;
      doneCnt = 0;
      start <= 1'b1;
      for (int i = 0; i < NL; i++) begin
         cfg[i] <= nextCfg[i];
      end
      @(posedge clk);
      if (poke) begin
         // a second start while busy, carrying a different configuration
         for (int i = 0; i < NL; i++) begin
            cfg[i] <= ~nextCfg[i];
         end
         @(posedge clk);
      end
      start <= 1'b0;
      ok = 1'b0;
      for (int c = 0; c < TIMEOUT && !ok; c++) begin
         @(posedge clk);
         ok = (doneCnt != 0);
      end
      if (!ok) begin
         $display("timeout after %0d cycles waiting for done", TIMEOUT);
         timedOut = 1'b1;
      end else begin
         @(posedge clk);
         if (doneCnt != 1) begin
            noteFault($sformatf("expected one done pulse, saw %0d", doneCnt));
         end
         if (busy !== 1'b0) begin
            logMismatch("busy", 32'(busy), 32'h0);
         end
         if (seenCnt != NL) begin
            logMismatch("burst count", 32'(seenCnt), 32'(NL));
         end
         for (int s = 0; s < seenCnt && s < 16; s++) begin
            hit = 1'b0;
            for (int i = 0; i < NL; i++) begin
               if (!hit && !used[i] && seenBursts[s].addr == nextCfg[i].extAddr
                   && seenBursts[s].len == nextCfg[i].len) begin
                  used[i] = 1'b1;
                  hit     = 1'b1;
               end
            end
            if (!hit) begin
               noteFault($sformatf("burst at %h len %0d matches no open lane burst",
                                   seenBursts[s].addr, seenBursts[s].len));
            end
         end
         for (int i = 0; i < NL; i++) begin
            if (gotCnt[i] != expCnt[i]) begin
               logMismatch($sformatf("laneOut[%0d] word count", i), 32'(gotCnt[i]),
                           32'(expCnt[i]));
            end
            for (int k = 0; primed[i] && k < expCnt[i] && k < gotCnt[i]; k++) begin
               if (gotWords[i][k] !== expWords[i][k]) begin
                  logMismatch($sformatf("laneOut[%0d].data word %0d", i, k),
                              gotWords[i][k], expWords[i][k]);
               end
            end
            for (int j = 0; j < int'(nextCfg[i].len); j++) begin
               a = nextCfg[i].extAddr[9:0] + 10'(j);
               bankImg[i][!modelBank[i]][j] = memTable[a];
            end
            modelBank[i] = !modelBank[i];
            primed[i]    = 1'b1;
         end
      end
   endtask

   initial begin
      int e0;
      rst       = 1'b1;
      start     = 1'b0;
      errors    = 0;
      testsRun  = 0;
      testsFailed = 0;
      timedOut  = 1'b0;
      seenCnt   = 0;
      doneCnt   = 0;
      reqSeen   = 1'b0;
      prevBusy  = 1'b0;
      lfsrState = 32'hbe06_7fa0;
      for (int i = 0; i < NL; i++) begin
         cfg[i]       = '0;
         gotCnt[i]    = 0;
         modelBank[i] = 1'b0;
         primed[i]    = 1'b0;
      end
      for (int w = 0; w < 1024; w++) begin
         memTable[w]        = randBits(32);
         responder.mem[w]   = memTable[w];
         responder.gaps[w]  = 2'(randBits(2));
      end
      repeat (3) @(posedge clk);
      rst <= 1'b0;

      e0 = errors;
      @(negedge clk);
      if (busy !== 1'b0) logMismatch("busy", 32'(busy), 32'h0);
      if (done !== 1'b0) logMismatch("done", 32'(done), 32'h0);
      if (extReq !== 1'b0) logMismatch("extReq", 32'(extReq), 32'h0);
      for (int i = 0; i < NL; i++) begin
         if (laneOut[i].valid !== 1'b0) begin
            logMismatch($sformatf("laneOut[%0d].valid", i), 32'(laneOut[i].valid), 32'h0);
         end
      end
      finishTest("reset state", e0);

      e0 = errors;
      for (int r = 0; r < 2 && !timedOut; r++) begin
         makeCfgs(0);
         runOnce(1'b0);
      end
      finishTest("ping-pong replay", e0);

      e0 = errors;
      for (int r = 0; r < 5 && !timedOut; r++) begin
         makeCfgs(1);
         runOnce(1'b0);
      end
      finishTest("stride and reversal", e0);

      e0 = errors;
      for (int r = 0; r < 4 && !timedOut; r++) begin
         makeCfgs(2);
         runOnce(1'b0);
      end
      finishTest("arbitration", e0);

      e0 = errors;
      for (int r = 0; r < 2 && !timedOut; r++) begin
         makeCfgs(1);
         runOnce(r == 0);
      end
      finishTest("completion", e0);

      $display("tests run %0d, failed %0d, errors %0d", testsRun, testsFailed, errors);
      if (errors == 0 && !timedOut) begin
         $display("Simulation completed successfully");
      end else begin
         $display("Simulation failed");
      end
      $finish;
   end

endmodule

/* vecRead.f */
design/busPkg.sv
design/lanePkg.sv
design/addrSweep.sv
design/pingPongBuffer.sv
design/readLane.sv
design/busArbiter.sv
design/laneLauncher.sv
design/vecReadTop.sv
dv/busResponder.sv
dv/vecReadTb.sv
